//--- hdl/softreg_pkg.sv
/* Shared SoftReg request/response types and address map constants.
   Imported by the RTL blocks and by the testbench to build addresses. */

package softreg_pkg;

	// --------------------------------------------------
	// Bus widths
	// --------------------------------------------------
	localparam int SR_ADDR_W = 32;
	localparam int SR_DATA_W = 64;

	// --------------------------------------------------
	// Address map
	// --------------------------------------------------
	// Registers are 8 bytes wide, index starts above the byte offset
	localparam int REG_SEL_LSB = 3;
	// Application index sits above a 4 KiB register window
	localparam int APP_SEL_LSB = 12;

	// Upper 56 bits of the identity register
	// Low byte carries the application index
	localparam logic [SR_DATA_W-9:0] ID_TAG = 56'h53_52_5f_41_50_50_01;

	// --------------------------------------------------
	// Payloads
	// --------------------------------------------------
	// Request, 98 bits
	typedef struct packed {
		logic                 valid;
		logic                 write;
		logic [SR_ADDR_W-1:0] addr;
		logic [SR_DATA_W-1:0] data;
	} softreg_req_t;

	// Response, 65 bits
	// Only reads produce one
	typedef struct packed {
		logic                 valid;
		logic [SR_DATA_W-1:0] data;
	} softreg_resp_t;

endpackage

//--- hdl/lib_pipe.sv
/* Fixed-depth register pipe for SoftReg payloads.
   Set T to the request or the response struct and STAGES to the depth. */

`timescale 1ns/1ps

module lib_pipe
	import softreg_pkg::*;
#(
	parameter type T      = softreg_resp_t,
	parameter int  STAGES = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  T     in_bus,
	output T     out_bus
);

	// One entry per stage, all in flight at once
	T stage_q [STAGES];

	// --------------------------------------------------
	// Shift register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			// Head takes the new item
			stage_q[0] <= in_bus;
			// Rest move one step toward the tail
			for (int i = 1; i < STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// Tail of the chain
	assign out_bus = stage_q[STAGES-1];

endmodule

//--- hdl/softreg_host_port.sv
/* Host side of the SoftReg path: gates requests while a read is pending,
   registers accepted requests toward the route tree and returns read data. */

`timescale 1ns/1ps

module softreg_host_port
	import softreg_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,

	// Host request bus, single-cycle valid
	input  logic                 sr_req_valid,
	input  logic                 sr_req_write,
	input  logic [SR_ADDR_W-1:0] sr_req_addr,
	input  logic [SR_DATA_W-1:0] sr_req_data,

	// Host status and read return
	output logic                 sr_busy,
	output logic                 sr_resp_valid,
	output logic [SR_DATA_W-1:0] sr_resp_data,

	// Toward the route tree
	output softreg_req_t         tree_req,
	input  softreg_resp_t        tree_resp
);

	logic         busy_q;
	logic         accept;
	softreg_req_t req_q;

	// Grant is implicit, anything seen while busy is dropped
	assign accept = sr_req_valid && !busy_q;

	// --------------------------------------------------
	// Request register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_q.valid <= 1'b0;
		end else begin
			req_q.valid <= accept;
		end
	end

	// Payload follows the host bus on every accept
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q.write <= sr_req_write;
			req_q.addr  <= sr_req_addr;
			req_q.data  <= sr_req_data;
		end
	end

	assign tree_req = req_q;

	// --------------------------------------------------
	// Outstanding read tracking
	// --------------------------------------------------
	// Set by an accepted read, cleared as its answer returns
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
		end else if (tree_resp.valid) begin
			busy_q <= 1'b0;
		end else if (accept && !sr_req_write) begin
			busy_q <= 1'b1;
		end
	end

	assign sr_busy = busy_q;

	// Tree merge stage already registers the answer
	assign sr_resp_valid = tree_resp.valid;
	assign sr_resp_data  = tree_resp.data;

	// A read answer with no read pending means a lost or duplicated response
	a_resp_only_when_busy : assert property (
		@(posedge clk) disable iff (!rst_n)
		tree_resp.valid |-> busy_q
	);

endmodule

//--- hdl/softreg_route_tree.sv
/* SoftReg route tree: steers each host request to one application lane
   through a pipe and merges the lanes' read answers into one response. */

`timescale 1ns/1ps

module softreg_route_tree
	import softreg_pkg::*;
#(
	parameter int NUM_APPS    = 4,
	parameter int PIPE_STAGES = 2
) (
	input  logic          clk,
	input  logic          rst_n,

	// Host side
	input  softreg_req_t  host_req,
	output softreg_resp_t host_resp,

	// Application side, one lane each
	output softreg_req_t  app_req  [NUM_APPS],
	input  softreg_resp_t app_resp [NUM_APPS]
);

	// Index field width, at least one bit
	localparam int APP_SEL_W = (NUM_APPS > 1) ? $clog2(NUM_APPS) : 1;

	logic [APP_SEL_W-1:0] app_sel;
	softreg_resp_t        lane_resp  [NUM_APPS];
	logic [NUM_APPS-1:0]  lane_valid;

	logic                 merge_valid;
	logic [SR_DATA_W-1:0] merge_data;
	softreg_resp_t        resp_q;

	// Application index from the address
	assign app_sel = host_req.addr[APP_SEL_LSB +: APP_SEL_W];

	// --------------------------------------------------
	// Per-application lanes
	// --------------------------------------------------
	for (genvar i = 0; i < NUM_APPS; i++) begin : g_lane
		softreg_req_t lane_req;

		// Payload goes to every lane
		// Valid only on the addressed one
		always_comb begin
			lane_req       = host_req;
			lane_req.valid = host_req.valid &&
				((NUM_APPS == 1) || (app_sel == APP_SEL_W'(i)));
		end

		lib_pipe #(
			.T      (softreg_req_t),
			.STAGES (PIPE_STAGES)
		) u_req_pipe (
			.clk     (clk),
			.rst_n   (rst_n),
			.in_bus  (lane_req),
			.out_bus (app_req[i])
		);

		lib_pipe #(
			.T      (softreg_resp_t),
			.STAGES (PIPE_STAGES)
		) u_resp_pipe (
			.clk     (clk),
			.rst_n   (rst_n),
			.in_bus  (app_resp[i]),
			.out_bus (lane_resp[i])
		);

		assign lane_valid[i] = lane_resp[i].valid;
	end

	// --------------------------------------------------
	// Response merge
	// --------------------------------------------------
	// Single outstanding read, so at most one lane answers
	always_comb begin
		merge_valid = 1'b0;
		merge_data  = '0;
		for (int i = 0; i < NUM_APPS; i++) begin
			if (lane_valid[i]) begin
				merge_valid = 1'b1;
				merge_data  = lane_resp[i].data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			resp_q.valid <= 1'b0;
		end else begin
			resp_q.valid <= merge_valid;
		end
	end

	// Data held until the next answer
	always_ff @(posedge clk) begin
		if (merge_valid) begin
			resp_q.data <= merge_data;
		end
	end

	assign host_resp = resp_q;

	// Relies on the host port letting only one read through at a time
	a_one_lane_valid : assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(lane_valid)
	);

endmodule

//--- hdl/app_scratch_regs.sv
/* Stand-in application: a bank of scratch registers on the SoftReg bus.
   Index 0 is a read-only identity word, other indices are read/write. */

`timescale 1ns/1ps

module app_scratch_regs
	import softreg_pkg::*;
#(
	parameter int APP_ID       = 0,
	parameter int REGS_PER_APP = 8
) (
	input  logic          clk,
	input  logic          rst_n,
	input  softreg_req_t  req,
	output softreg_resp_t resp
);

	localparam int REG_SEL_W = $clog2(REGS_PER_APP);

	logic [SR_DATA_W-1:0] regs_q [REGS_PER_APP];
	logic [REG_SEL_W-1:0] reg_sel;
	logic [SR_DATA_W-1:0] id_word;
	logic                 wr_fire;
	logic                 rd_fire;
	logic                 resp_valid_q;
	logic [SR_DATA_W-1:0] resp_data_q;

	// Register index from the address
	assign reg_sel = req.addr[REG_SEL_LSB +: REG_SEL_W];

	// Tag above the app index byte
	assign id_word = {ID_TAG, 8'(APP_ID)};

	assign wr_fire = req.valid && req.write;
	assign rd_fire = req.valid && !req.write;

	// --------------------------------------------------
	// Scratch storage
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REGS_PER_APP; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_fire && (reg_sel != '0)) begin
			// Identity slot is read-only
			regs_q[reg_sel] <= req.data;
		end
	end

	// --------------------------------------------------
	// Read return one cycle after the request
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			resp_valid_q <= 1'b0;
		end else begin
			resp_valid_q <= rd_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			resp_data_q <= (reg_sel == '0) ? id_word : regs_q[reg_sel];
		end
	end

	assign resp.valid = resp_valid_q;
	assign resp.data  = resp_data_q;

	// Only one read in flight upstream, so each answer is a single-cycle pulse
	a_resp_single_pulse : assert property (
		@(posedge clk) disable iff (!rst_n)
		resp.valid |=> !resp.valid
	);

endmodule

//--- hdl/softreg_shell.sv
/* Top of the SoftReg control path: host port, route tree and one
   scratch register block per application. */

`timescale 1ns/1ps

module softreg_shell
	import softreg_pkg::*;
#(
	parameter int NUM_APPS     = 4,
	parameter int REGS_PER_APP = 8,
	parameter int PIPE_STAGES  = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,

	// Host request bus
	input  logic                 sr_req_valid,
	input  logic                 sr_req_write,
	input  logic [SR_ADDR_W-1:0] sr_req_addr,
	input  logic [SR_DATA_W-1:0] sr_req_data,

	// Host status and read return
	output logic                 sr_busy,
	output logic                 sr_resp_valid,
	output logic [SR_DATA_W-1:0] sr_resp_data
);

	// Host port to tree
	softreg_req_t  tree_req;
	softreg_resp_t tree_resp;

	// Tree to applications
	softreg_req_t  app_req  [NUM_APPS];
	softreg_resp_t app_resp [NUM_APPS];

	// --------------------------------------------------
	// Host port
	// --------------------------------------------------
	softreg_host_port u_host_port (
		.clk           (clk),
		.rst_n         (rst_n),
		.sr_req_valid  (sr_req_valid),
		.sr_req_write  (sr_req_write),
		.sr_req_addr   (sr_req_addr),
		.sr_req_data   (sr_req_data),
		.sr_busy       (sr_busy),
		.sr_resp_valid (sr_resp_valid),
		.sr_resp_data  (sr_resp_data),
		.tree_req      (tree_req),
		.tree_resp     (tree_resp)
	);

	// --------------------------------------------------
	// Route tree
	// --------------------------------------------------
	softreg_route_tree #(
		.NUM_APPS    (NUM_APPS),
		.PIPE_STAGES (PIPE_STAGES)
	) u_route_tree (
		.clk       (clk),
		.rst_n     (rst_n),
		.host_req  (tree_req),
		.host_resp (tree_resp),
		.app_req   (app_req),
		.app_resp  (app_resp)
	);

	// --------------------------------------------------
	// Applications
	// --------------------------------------------------
	for (genvar app_num = 0; app_num < NUM_APPS; app_num++) begin : g_app
		app_scratch_regs #(
			.APP_ID       (app_num),
			.REGS_PER_APP (REGS_PER_APP)
		) u_app (
			.clk   (clk),
			.rst_n (rst_n),
			.req   (app_req[app_num]),
			.resp  (app_resp[app_num])
		);
	end

endmodule

//--- verif/softreg_shell_tb.sv
/* Testbench for the SoftReg shell. Runs the request sequence from the pattern file
   and checks read data, read latency and the busy handshake. */

`timescale 1ns/1ps

module softreg_shell_tb
	import softreg_pkg::*;
();

	// --------------------------------------------------
	// Configuration
	// --------------------------------------------------
	localparam int NUM_APPS     = 4;
	localparam int REGS_PER_APP = 8;
	localparam int PIPE_STAGES  = 2;

	// Host port, request pipe, app, response pipe, merge
	localparam int READ_LATENCY = PIPE_STAGES * 2 + 3;
	localparam int RESP_TIMEOUT = 40;

	localparam int CLK_HALF     = 4;
	localparam int DRIVE_DELAY  = 1;
	localparam int RESET_CYCLES = 4;

	localparam string PATTERN_FILE = "verif/softreg_patterns.txt";

	logic                 clk;
	logic                 rst_n;
	logic                 sr_req_valid;
	logic                 sr_req_write;
	logic [SR_ADDR_W-1:0] sr_req_addr;
	logic [SR_DATA_W-1:0] sr_req_data;
	logic                 sr_busy;
	logic                 sr_resp_valid;
	logic [SR_DATA_W-1:0] sr_resp_data;

	// Pattern lines actually executed
	int ops_done;

	softreg_shell #(
		.NUM_APPS     (NUM_APPS),
		.REGS_PER_APP (REGS_PER_APP),
		.PIPE_STAGES  (PIPE_STAGES)
	) uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.sr_req_valid  (sr_req_valid),
		.sr_req_write  (sr_req_write),
		.sr_req_addr   (sr_req_addr),
		.sr_req_data   (sr_req_data),
		.sr_busy       (sr_busy),
		.sr_resp_valid (sr_resp_valid),
		.sr_resp_data  (sr_resp_data)
	);

	// 8 ns clock
	initial clk = 1'b0;
	always #CLK_HALF clk = ~clk;

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
			input string what);
		if (got !== exp) begin
			stop_with_failure($sformatf("error: %0t ns %s got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	// Inputs change and outputs are sampled just after the edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Byte address of one register of one application
	function automatic logic [SR_ADDR_W-1:0] build_addr(input int app, input int idx);
		build_addr = (SR_ADDR_W'(app) << APP_SEL_LSB) | (SR_ADDR_W'(idx) << REG_SEL_LSB);
	endfunction

	// Tag in the upper 56 bits, application index in the low byte
	function automatic logic [SR_DATA_W-1:0] id_word(input int app);
		id_word = (SR_DATA_W'(ID_TAG) << 8) | SR_DATA_W'(app);
	endfunction

	task automatic drive_idle();
		sr_req_valid = 1'b0;
		sr_req_write = 1'b0;
		sr_req_addr  = '0;
		sr_req_data  = '0;
	endtask

	task automatic drive_request(input logic write, input logic [SR_ADDR_W-1:0] addr,
			input logic [SR_DATA_W-1:0] data);
		sr_req_valid = 1'b1;
		sr_req_write = write;
		sr_req_addr  = addr;
		sr_req_data  = data;
	endtask

	// --------------------------------------------------
	// Bus operations
	// --------------------------------------------------
	// Write gives no answer and must not raise busy
	task automatic write_reg(input int app, input int idx, input logic [SR_DATA_W-1:0] data);
		drive_request(1'b1, build_addr(app, idx), data);
		next_cycle();
		drive_idle();
		check_value(64'(sr_busy), 64'd0, "sr_busy after write");
		check_value(64'(sr_resp_valid), 64'd0, "sr_resp_valid after write");
	endtask

	// Read with latency and busy checks
	// Optionally pushes a write while the read is still pending
	task automatic read_reg(input int app, input int idx, input logic [SR_DATA_W-1:0] exp,
			input bit blocked_write, input int blocked_idx,
			input logic [SR_DATA_W-1:0] blocked_data);
		int cycles;
		bit seen;
		drive_request(1'b0, build_addr(app, idx), '0);
		next_cycle();
		drive_idle();
		cycles = 1;
		seen = 1'b0;
		while (!seen) begin
			if (cycles > RESP_TIMEOUT) begin
				stop_with_failure("timeout: the DUT never returned read data");
			end else begin
				// Busy from t+1 until the answer cycle
				check_value(64'(sr_busy), 64'd1, "sr_busy while read pending");
				if (sr_resp_valid) begin
					check_value(64'(cycles), 64'(READ_LATENCY), "read latency");
					check_value(sr_resp_data, exp, "read data");
					seen = 1'b1;
				end else if (blocked_write && cycles == 2) begin
					drive_request(1'b1, build_addr(app, blocked_idx), blocked_data);
				end
				next_cycle();
				drive_idle();
				cycles++;
			end
		end
		// Single answer and busy low again in t+8
		check_value(64'(sr_resp_valid), 64'd0, "sr_resp_valid after answer");
		check_value(64'(sr_busy), 64'd0, "sr_busy after answer");
	endtask

	// --------------------------------------------------
	// Pattern file
	// --------------------------------------------------
	task automatic run_patterns();
		int fd;
		int code;
		int fields;
		int app;
		int idx;
		int line_no;
		string line;
		logic [7:0] op;
		logic [SR_DATA_W-1:0] value;
		logic [SR_DATA_W-1:0] expected;
		line_no = 0;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			stop_with_failure("could not open the pattern file verif/softreg_patterns.txt");
		end else begin
			code = $fgets(line, fd);
			while (code != 0) begin
				line_no++;
				op = line.getc(0);
				// Comments and blank lines are skipped
				if (op != "#" && op != "\n" && op != "\r" && op != " " && op != "\t") begin
					fields = $sscanf(line.substr(1, line.len() - 1), "%d %d %h",
						app, idx, value);
					if (fields != 3) begin
						stop_with_failure($sformatf("pattern line %0d is malformed", line_no));
					end else if (app < 0 || app >= NUM_APPS ||
							idx < 0 || idx >= REGS_PER_APP) begin
						stop_with_failure($sformatf("pattern line %0d is out of range",
							line_no));
					end else begin
						case (op)
							"W": write_reg(app, idx, value);
							"R": begin
								// Index 0 always reads the identity word
								expected = (idx == 0) ? id_word(app) : value;
								read_reg(app, idx, expected, 1'b0, 0, '0);
							end
							// Identity read keeps busy high while the write is offered
							"B": read_reg(app, 0, id_word(app), 1'b1, idx, value);
							default: stop_with_failure($sformatf(
								"pattern line %0d has an unknown operation", line_no));
						endcase
						ops_done++;
					end
				end
				code = $fgets(line, fd);
			end
			$fclose(fd);
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		rst_n = 1'b0;
		drive_idle();
		ops_done = 0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
		end
		#DRIVE_DELAY;
		rst_n = 1'b1;
		next_cycle();
		check_value(64'(sr_busy), 64'd0, "sr_busy after reset");
		check_value(64'(sr_resp_valid), 64'd0, "sr_resp_valid after reset");
		run_patterns();
		if (ops_done == 0) begin
			stop_with_failure("the pattern file held no operations");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

//--- verif/softreg_patterns.txt
# op app reg data: W writes data, R reads and expects data, B writes data while a read is pending
# reads of reg 0 expect the identity word, their data column is unused
R 0 1 0000000000000000
R 1 3 0000000000000000
R 2 5 0000000000000000
R 3 7 0000000000000000
R 0 0 0000000000000000
R 1 0 0000000000000000
R 2 0 0000000000000000
R 3 0 0000000000000000
W 0 1 1111111111111111
W 1 1 2222222222222222
W 2 1 3333333333333333
W 3 1 4444444444444444
R 0 1 1111111111111111
R 1 1 2222222222222222
R 2 1 3333333333333333
R 3 1 4444444444444444
W 2 7 0123456789abcdef
R 2 7 0123456789abcdef
W 2 7 fedcba9876543210
R 2 7 fedcba9876543210
R 2 1 3333333333333333
W 1 6 a5a5a5a55a5a5a5a
R 1 6 a5a5a5a55a5a5a5a
W 1 0 00000000deadbeef
R 1 0 0000000000000000
W 3 0 ffffffffffffffff
R 3 0 0000000000000000
W 0 4 aaaaaaaaaaaaaaaa
B 0 4 5555555555555555
R 0 4 aaaaaaaaaaaaaaaa
B 3 7 0f0f0f0f0f0f0f0f
R 3 7 0000000000000000
B 2 2 1234123412341234
R 2 2 0000000000000000
W 3 5 cafef00dcafef00d
R 3 5 cafef00dcafef00d
R 0 5 0000000000000000
R 1 1 2222222222222222

//--- list.f
hdl/softreg_pkg.sv
hdl/lib_pipe.sv
hdl/softreg_host_port.sv
hdl/softreg_route_tree.sv
hdl/app_scratch_regs.sv
hdl/softreg_shell.sv
verif/softreg_shell_tb.sv

//--- Makefile
# Verilator build for the SoftReg shell and its testbench
TOP = softreg_shell_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module softreg_shell
	verilator --lint-only --timing -f list.f --top-module $(TOP)

# A $fatal in the testbench makes the binary exit with a failing status
sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
